/* mac_test_pkg.sv */
/*
 * mac loopback tester shared types
 * widths, CRC and scrambler constants, stream structs and FSM states
 */
package mac_test_pkg;

    typedef logic [7:0]  byte_t;
    typedef logic [7:0]  frame_len_t;  // payload length, 1 to 255
    typedef logic [15:0] frame_cnt_t;
    typedef logic [31:0] crc_t;
    typedef logic [15:0] lfsr_t;

    // x^16+x^15+x^13+x^4+1, Fibonacci form with the state shifting left
    localparam lfsr_t SCRAMBLER_INIT = 16'h55AA;
    localparam lfsr_t SCRAMBLER_TAPS = 16'hD008;

    localparam crc_t CRC_POLY    = 32'hEDB88320;
    localparam crc_t CRC_INIT    = 32'hFFFFFFFF;
    localparam crc_t CRC_RESIDUE = 32'hDEBB20E3;  // raw register after data plus FCS
    localparam int   FCS_BYTES   = 4;

    typedef struct packed {
        byte_t data;
        logic  valid;
        logic  sof;
        logic  eof;
    } mac_stream_t;

    typedef struct packed {
        logic cmp;  // payload mismatch
        logic crc;
        logic fr;   // error reported by the PHY
    } rx_err_t;

    typedef enum logic [1:0] {TX_IDLE, TX_PAYLOAD, TX_FCS} tx_state_t;

    typedef enum logic [1:0] {RX_IDLE, RX_RXSTART, RX_RX, RX_ERR} rx_state_t;

endpackage

/* lfsr_scrambler.sv */
/*
 * 16-bit LFSR data scrambler
 * advances eight steps per enabled byte, reloads on load
 */
`timescale 1ns/1ps

module lfsr_scrambler import mac_test_pkg::*; (
    input  logic  clk,
    input  logic  rst_n,
    input  logic  load,
    input  logic  en,
    output byte_t data
);

    lfsr_t state;

    function automatic lfsr_t step8(lfsr_t s);
        lfsr_t t;
        t = s;
        for (int i = 0; i < 8; i++) begin
            t = {t[14:0], ^(t & SCRAMBLER_TAPS)};
        end
        return t;
    endfunction

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= SCRAMBLER_INIT;
        end else if (load) begin
            state <= SCRAMBLER_INIT;
        end else if (en) begin
            state <= step8(state);
        end
    end

    assign data = state[7:0];  // byte consumed on the cycle en is high

endmodule

/* crc32_byte.sv */
/*
 * byte-wide Ethernet CRC-32 accumulator
 * reflected update, clear restarts the register from all ones
 */
`timescale 1ns/1ps

module crc32_byte import mac_test_pkg::*; (
    input  logic  clk,
    input  logic  rst_n,
    input  logic  clear,
    input  logic  en,
    input  byte_t data,
    output crc_t  crc
);

    crc_t seed;

    function automatic crc_t crc_update(crc_t c, byte_t d);
        crc_t t;
        t = c ^ {24'd0, d};
        for (int i = 0; i < 8; i++) begin
            t = t[0] ? ((t >> 1) ^ CRC_POLY) : (t >> 1);
        end
        return t;
    endfunction

    // clear with en folds the first byte of a new frame in straight away
    assign seed = clear ? CRC_INIT : crc;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            crc <= CRC_INIT;
        end else if (en) begin
            crc <= crc_update(seed, data);
        end else if (clear) begin
            crc <= CRC_INIT;
        end
    end

endmodule

/* frame_tx_gen.sv */
/*
 * frame generator
 * sends len scrambled payload bytes, then the four FCS bytes LSB first
 */
`timescale 1ns/1ps

module frame_tx_gen import mac_test_pkg::*; (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        arm,
    input  logic        send,
    input  frame_len_t  len,
    output mac_stream_t tx,
    output logic        busy
);

    tx_state_t  state;
    frame_len_t cnt;
    frame_len_t last_idx;
    byte_t      scr_data;
    crc_t       crc;
    crc_t       fcs;
    logic       pay_beat;
    logic       first_beat;

    assign pay_beat   = (state == TX_PAYLOAD);
    assign first_beat = pay_beat && (cnt == '0);
    assign fcs        = ~crc;

    // scrambler keeps running across frames, only arm restarts it
    lfsr_scrambler scr_i (
        .clk  (clk),
        .rst_n(rst_n),
        .load (arm),
        .en   (pay_beat),
        .data (scr_data)
    );

    crc32_byte crc_i (
        .clk  (clk),
        .rst_n(rst_n),
        .clear(first_beat),
        .en   (pay_beat),
        .data (scr_data),
        .crc  (crc)
    );

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= TX_IDLE;
            cnt   <= '0;
        end else begin
            case (state)
                TX_IDLE: begin
                    if (send) begin  // send while busy falls through the other states
                        state <= TX_PAYLOAD;
                        cnt   <= '0;
                    end
                end
                TX_PAYLOAD: begin
                    if (cnt == last_idx) begin
                        state <= TX_FCS;
                        cnt   <= '0;
                    end else begin
                        cnt <= cnt + 1'b1;
                    end
                end
                TX_FCS: begin
                    if (cnt == frame_len_t'(FCS_BYTES - 1)) begin
                        state <= TX_IDLE;
                    end else begin
                        cnt <= cnt + 1'b1;
                    end
                end
                default: state <= TX_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == TX_IDLE && send) begin
            last_idx <= len - 8'd1;
        end
    end

    always_comb begin
        tx.valid = (state != TX_IDLE);
        tx.sof   = first_beat;
        tx.eof   = (state == TX_FCS) && (cnt == frame_len_t'(FCS_BYTES - 1));
        tx.data  = pay_beat ? scr_data : fcs[{cnt[1:0], 3'b000} +: 8];
    end

    assign busy = (state != TX_IDLE);

endmodule

/* rx_fcs_strip.sv */
/*
 * receive FCS stage
 * holds back four bytes, strips the FCS and flags the frame at payload eof
 */
`timescale 1ns/1ps

module rx_fcs_strip import mac_test_pkg::*; (
    input  logic        clk,
    input  logic        rst_n,
    input  mac_stream_t rx,
    input  logic        rx_fr_err,
    output mac_stream_t payload,
    output logic        fr_good,
    output logic        fr_err
);

    byte_t              sr_data [FCS_BYTES];
    logic [FCS_BYTES-1:0] sr_sof;
    logic [2:0]         fill;
    logic               err_acc;
    logic               err_next;
    logic               release_beat;
    crc_t               crc;

    crc32_byte crc_i (
        .clk  (clk),
        .rst_n(rst_n),
        .clear(rx.valid && rx.sof),
        .en   (rx.valid),
        .data (rx.data),
        .crc  (crc)
    );

    // oldest held byte leaves once four newer bytes stand behind it
    assign release_beat = rx.valid && !rx.sof && (fill == 3'(FCS_BYTES));
    assign err_next     = (err_acc && !rx.sof) || rx_fr_err;

    always_ff @(posedge clk) begin
        if (rx.valid) begin
            sr_data[0] <= rx.data;
            sr_sof[0]  <= rx.sof;
            for (int i = 1; i < FCS_BYTES; i++) begin
                sr_data[i] <= sr_data[i-1];
                sr_sof[i]  <= sr_sof[i-1];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            fill    <= '0;
            err_acc <= 1'b0;
            payload <= '0;
        end else begin
            if (rx.valid) begin
                err_acc <= err_next;
                if (rx.eof) begin
                    fill <= '0;
                end else if (rx.sof) begin
                    fill <= 3'd1;
                end else if (fill != 3'(FCS_BYTES)) begin
                    fill <= fill + 1'b1;
                end
            end
            payload.valid <= release_beat;
            payload.data  <= sr_data[FCS_BYTES-1];
            payload.sof   <= release_beat && sr_sof[FCS_BYTES-1];
            payload.eof   <= release_beat && rx.eof;  // last FCS byte in means last payload byte out
        end
    end

    // both registers still hold the finished frame during the payload eof beat
    assign fr_good = payload.eof && (crc == CRC_RESIDUE);
    assign fr_err  = payload.eof && err_acc;

endmodule

/* frame_rx_check.sv */
/*
 * receive checker
 * compares payload against a local scrambler, latches error causes, counts good frames
 */
`timescale 1ns/1ps

module frame_rx_check import mac_test_pkg::*; (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        arm,
    input  mac_stream_t payload,
    input  logic        fr_good,
    input  logic        fr_err,
    output rx_err_t     err,
    output logic        err_any,
    output frame_cnt_t  good_cnt
);

    rx_state_t state;
    byte_t     scr_data;
    logic      check_beat;
    logic      mism;
    logic      crc_bad;
    logic      fr_bad;

    // bytes before the first sof after arm are not checked
    assign check_beat = payload.valid &&
                        ((state == RX_RX) || (state == RX_RXSTART && payload.sof));

    assign mism    = (payload.data != scr_data);
    assign crc_bad = payload.eof && !fr_good;
    assign fr_bad  = payload.eof && fr_err;

    lfsr_scrambler scr_i (
        .clk  (clk),
        .rst_n(rst_n),
        .load (arm),
        .en   (check_beat),
        .data (scr_data)
    );

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state    <= RX_IDLE;
            err      <= '0;
            err_any  <= 1'b0;
            good_cnt <= '0;
        end else if (arm) begin
            state   <= RX_RXSTART;  // good_cnt is kept across arm
            err     <= '0;
            err_any <= 1'b0;
        end else if (state == RX_ERR) begin
            err_any <= |err;  // held here until the next arm
        end else if (check_beat) begin
            if (mism || crc_bad || fr_bad) begin
                err.cmp <= mism;
                err.crc <= crc_bad;
                err.fr  <= fr_bad;
                state   <= RX_ERR;
            end else begin
                state <= RX_RX;
                if (payload.eof) begin
                    good_cnt <= good_cnt + 1'b1;
                end
            end
        end
    end

endmodule

/* mac_test_top.sv */
/*
 * loopback frame tester top
 * generator on the transmit side, FCS stage and checker on the receive side
 */
`timescale 1ns/1ps

module mac_test_top import mac_test_pkg::*; (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        arm,
    input  logic        send,
    input  frame_len_t  len,
    output mac_stream_t mac_tx,
    output logic        tx_busy,
    input  mac_stream_t mac_rx,
    input  logic        mac_rx_fr_err,
    output rx_err_t     err,
    output logic        err_any,
    output frame_cnt_t  good_cnt
);

    mac_stream_t payload;
    logic        fr_good;
    logic        fr_err;

    frame_tx_gen tx_gen_i (
        .clk  (clk),
        .rst_n(rst_n),
        .arm  (arm),
        .send (send),
        .len  (len),
        .tx   (mac_tx),
        .busy (tx_busy)
    );

    rx_fcs_strip fcs_strip_i (
        .clk      (clk),
        .rst_n    (rst_n),
        .rx       (mac_rx),
        .rx_fr_err(mac_rx_fr_err),
        .payload  (payload),
        .fr_good  (fr_good),
        .fr_err   (fr_err)
    );

    frame_rx_check rx_check_i (
        .clk     (clk),
        .rst_n   (rst_n),
        .arm     (arm),
        .payload (payload),
        .fr_good (fr_good),
        .fr_err  (fr_err),
        .err     (err),
        .err_any (err_any),
        .good_cnt(good_cnt)
    );

endmodule

/* mac_test_checker.sv */
/*
 * bound checks on the receive checker
 * payload framing, error latching and the good-frame counter
 */
`timescale 1ns/1ps

module mac_test_checker import mac_test_pkg::*; (
    input logic        clk,
    input logic        rst_n,
    input logic        arm,
    input mac_stream_t payload,
    input rx_state_t   state,
    input logic        err_any,
    input frame_cnt_t  good_cnt
);

    int fail_cnt = 0;  // read by the testbench at the end of the run

    sof_with_valid: assert property (@(posedge clk) disable iff (!rst_n)
        payload.sof |-> payload.valid)
    else begin
        $error("payload sof seen without valid");
        fail_cnt = fail_cnt + 1;
    end

    // err_any only drops on the cycle after an arm pulse
    err_any_held: assert property (@(posedge clk) disable iff (!rst_n)
        $fell(err_any) |-> $past(arm))
    else begin
        $error("err_any cleared without arm");
        fail_cnt = fail_cnt + 1;
    end

    cnt_frozen_in_err: assert property (@(posedge clk) disable iff (!rst_n)
        ($past(state) == RX_ERR) |-> $stable(good_cnt))
    else begin
        $error("good_cnt changed while the checker was in the error state");
        fail_cnt = fail_cnt + 1;
    end

endmodule

/* tb_mac_test.sv */
/*
 * loopback testbench for the mac frame tester
 * table of frames with optional corruption, checked after each frame
 */
`timescale 1ns/1ps

module tb_mac_test;
    import mac_test_pkg::*;

    typedef enum logic [1:0] {K_NONE, K_PAY, K_FCS, K_FRERR} corrupt_t;

    typedef struct packed {
        logic       arm;
        frame_len_t len;
        corrupt_t   kind;
        logic [8:0] idx;     // byte position in the frame, FCS included
        logic       resend;  // second send while busy
        logic       inc;
        rx_err_t    err;     // cmp crc fr
    } row_t;

    logic        clk = 1'b0;
    logic        rst_n;
    logic        arm;
    logic        send;
    frame_len_t  len;
    mac_stream_t mac_tx;
    logic        tx_busy;
    mac_stream_t mac_rx = '0;
    logic        mac_rx_fr_err = 1'b0;
    rx_err_t     err;
    logic        err_any;
    frame_cnt_t  good_cnt;

    row_t       rows[14];
    corrupt_t   cur_kind;
    logic [8:0] cur_idx;
    logic [8:0] byte_cnt = '0;
    logic [8:0] tx_pos;
    int         seed = 92832;
    int         wd_cycles = 0;
    int         tests_passed = 0;
    int         tests_failed = 0;
    logic       row_bad;

    mac_test_top mac_test_top_i (
        .clk          (clk),
        .rst_n        (rst_n),
        .arm          (arm),
        .send         (send),
        .len          (len),
        .mac_tx       (mac_tx),
        .tx_busy      (tx_busy),
        .mac_rx       (mac_rx),
        .mac_rx_fr_err(mac_rx_fr_err),
        .err          (err),
        .err_any      (err_any),
        .good_cnt     (good_cnt)
    );

    bind frame_rx_check mac_test_checker checker_i (
        .clk     (clk),
        .rst_n   (rst_n),
        .arm     (arm),
        .payload (payload),
        .state   (state),
        .err_any (err_any),
        .good_cnt(good_cnt)
    );

    always #5 clk = ~clk;

    // loopback with one register stage, corrupting the selected byte
    assign tx_pos = mac_tx.sof ? 9'd0 : byte_cnt;

    always @(posedge clk) begin
        mac_rx        <= mac_tx;
        mac_rx_fr_err <= 1'b0;
        if (mac_tx.valid) begin
            byte_cnt <= tx_pos + 9'd1;
            if (tx_pos == cur_idx) begin
                case (cur_kind)
                    K_PAY, K_FCS: mac_rx.data <= mac_tx.data ^ 8'h10;
                    K_FRERR:      mac_rx_fr_err <= 1'b1;
                    default:      ;
                endcase
            end
        end
    end

    function automatic int rand_below(int n);
        return int'({$random(seed)} % n);
    endfunction

    function automatic frame_len_t rand_len();
        return frame_len_t'(2 + rand_below(120));
    endfunction

    task automatic build_table();
        frame_len_t l;
        rows[0] = '{1'b1, 8'd1, K_NONE, 9'd0, 1'b0, 1'b1, 3'b000};
        rows[1] = '{1'b0, 8'd2, K_NONE, 9'd0, 1'b0, 1'b1, 3'b000};
        rows[2] = '{1'b0, rand_len(), K_NONE, 9'd0, 1'b0, 1'b1, 3'b000};
        rows[3] = '{1'b0, rand_len(), K_NONE, 9'd0, 1'b0, 1'b1, 3'b000};
        l = rand_len();
        rows[4] = '{1'b0, l, K_PAY, 9'(rand_below(int'(l) - 1)), 1'b0, 1'b0, 3'b100};
        rows[5] = '{1'b0, rand_len(), K_NONE, 9'd0, 1'b0, 1'b0, 3'b100};  // still in error
        rows[6] = '{1'b1, rand_len(), K_NONE, 9'd0, 1'b0, 1'b1, 3'b000};
        rows[7] = '{1'b0, rand_len(), K_NONE, 9'd0, 1'b0, 1'b1, 3'b000};
        l = rand_len();
        rows[8] = '{1'b0, l, K_FCS, 9'(int'(l) + rand_below(4)), 1'b0, 1'b0, 3'b010};
        l = rand_len();
        rows[9] = '{1'b1, l, K_FRERR, 9'(rand_below(int'(l) + 4)), 1'b0, 1'b0, 3'b001};
        // flipped last payload byte also breaks the CRC on the same beat
        l = rand_len();
        rows[10] = '{1'b1, l, K_PAY, 9'(int'(l) - 1), 1'b0, 1'b0, 3'b110};
        rows[11] = '{1'b1, 8'd3, K_NONE, 9'd0, 1'b1, 1'b1, 3'b000};
        rows[12] = '{1'b0, rand_len(), K_NONE, 9'd0, 1'b0, 1'b1, 3'b000};
        rows[13] = '{1'b0, 8'd255, K_NONE, 9'd0, 1'b0, 1'b1, 3'b000};
    endtask

    task automatic run_row(input row_t row, output int busy_len);
        if (row.arm) begin
            arm <= 1'b1;
            @(posedge clk);
            arm <= 1'b0;
        end
        cur_kind <= row.kind;
        cur_idx  <= row.idx;
        send     <= 1'b1;
        len      <= row.len;
        @(posedge clk);
        send <= row.resend;  // a second request reaches the generator while it is busy
        @(posedge clk);
        send     <= 1'b0;
        busy_len = 0;
        while (tx_busy) begin
            busy_len++;
            @(posedge clk);
        end
        repeat (4) @(posedge clk);
    endtask

    task automatic check_value(input string name, input int got, input int exp);
        assert (got == exp) else begin
            $display("Mismatch at %0t: %s expected 0x%0h got 0x%0h", $time, name, exp, got);
            row_bad = 1'b1;
        end
    endtask

    task automatic report_test(input int n);
        if (row_bad) begin
            tests_failed++;
            $display("test %0d failed", n);
        end else begin
            tests_passed++;
            $display("test %0d ok", n);
        end
    endtask

    initial begin
        wait (wd_cycles > 0);
        repeat (wd_cycles) @(posedge clk);
        $display("watchdog expired after %0d cycles, the run did not finish", wd_cycles);
        $display("RESULT: FAIL");
        $finish;
    end

    initial begin
        int exp_cnt;
        int total;
        int busy_len;
        exp_cnt  = 0;
        total    = 100;  // margin for reset and the final checks
        rst_n    = 1'b0;
        arm      = 1'b0;
        send     = 1'b0;
        len      = '0;
        cur_kind = K_NONE;
        cur_idx  = '0;
        build_table();
        foreach (rows[i]) total += int'(rows[i].len) + 20;
        wd_cycles = total;

        repeat (3) @(posedge clk);
        rst_n <= 1'b1;
        @(posedge clk);
        @(posedge clk);
        row_bad = 1'b0;
        check_value("err", int'(err), 0);
        check_value("good_cnt", int'(good_cnt), 0);
        check_value("tx_busy", int'(tx_busy), 0);
        check_value("mac_tx.valid", int'(mac_tx.valid), 0);
        report_test(0);

        for (int r = 0; r < $size(rows); r++) begin
            run_row(rows[r], busy_len);
            exp_cnt = exp_cnt + int'(rows[r].inc);
            row_bad = 1'b0;
            check_value("good_cnt", int'(good_cnt), exp_cnt);
            check_value("err", int'(err), int'(rows[r].err));
            check_value("err_any", int'(err_any), int'(|rows[r].err));
            // one frame is len payload bytes plus the FCS
            check_value("tx_busy cycles", busy_len, int'(rows[r].len) + FCS_BYTES);
            report_test(r + 1);
        end

        assert (mac_test_top_i.rx_check_i.checker_i.fail_cnt == 0) else begin
            $display("bound checker saw %0d assertion failures",
                     mac_test_top_i.rx_check_i.checker_i.fail_cnt);
            tests_failed++;
        end

        $display("tests passed %0d, failed %0d", tests_passed, tests_failed);
        if (tests_failed == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

/* flist.f */
mac_test_pkg.sv
lfsr_scrambler.sv
crc32_byte.sv
frame_tx_gen.sv
rx_fcs_strip.sv
frame_rx_check.sv
mac_test_top.sv
mac_test_checker.sv
tb_mac_test.sv

/* Makefile */
SIM        = verilator
FLAGS      = --binary --timing --assert -j 0
LINT_FLAGS = --lint-only --timing --assert
TOP        = tb_mac_test
FLIST      = flist.f
OBJ_DIR    = obj_dir
LOG        = sim.log
PASS_MSG   = RESULT: PASS

.PHONY: all build run lint clean

all: run

build:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(OBJ_DIR)

run: build
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

lint:
	$(SIM) $(LINT_FLAGS) --top-module $(TOP) -f $(FLIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
